// ==== Makefile ====
.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing -f ext_mem.f --top-module tb_ext_mem -Mdir obj_dir

run: build
	./obj_dir/Vtb_ext_mem | tee sim.log
	grep -q "sim passed" sim.log

lint:
	verilator --lint-only -f ext_mem.f --top-module ext_mem

clean:
	rm -rf obj_dir sim.log

// ==== ext_mem.f ====
rtl/ext_mem_pkg.sv
rtl/mem_bus_if.sv
rtl/l1_cache.sv
rtl/bus_merge.sv
rtl/axil_master.sv
rtl/ext_mem.sv
tests/ext_mem_checker.sv
tests/tb_ext_mem.sv

// ==== rtl/axil_master.sv ====
`default_nettype none

module axil_master (
   input  logic                             clk,
   input  logic                             rst,
   mem_bus_if.slave                         native,
   output logic [ext_mem_pkg::ADDR_W-1:0]   awaddr,
   output logic [2:0]                       awprot,
   output logic                             awvalid,
   input  logic                             awready,
   output logic [ext_mem_pkg::DATA_W-1:0]   wdata,
   output logic [ext_mem_pkg::STRB_W-1:0]   wstrb,
   output logic                             wvalid,
   input  logic                             wready,
   input  logic [1:0]                       bresp,   // Not checked
   input  logic                             bvalid,
   output logic                             bready,
   output logic [ext_mem_pkg::ADDR_W-1:0]   araddr,
   output logic [2:0]                       arprot,
   output logic                             arvalid,
   input  logic                             arready,
   input  logic [ext_mem_pkg::DATA_W-1:0]   rdata,
   input  logic [1:0]                       rresp,   // Not checked
   input  logic                             rvalid,
   output logic                             rready
);
   import ext_mem_pkg::*;

   axil_state_e state;
   logic        aw_pend_q;
   logic        w_pend_q;
   logic        ready_q;
   logic        aw_done;
   logic        w_done;

   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] wstrb_q;
   logic [DATA_W-1:0] rdata_q;

   // AW and W may complete in either order
   assign aw_done = !aw_pend_q || awready;
   assign w_done  = !w_pend_q || wready;

   assign awaddr  = addr_q;
   assign awprot  = 3'b000;
   assign awvalid = (state == axil_write_addr_data) && aw_pend_q;
   assign wdata   = wdata_q;
   assign wstrb   = wstrb_q;
   assign wvalid  = (state == axil_write_addr_data) && w_pend_q;
   assign bready  = (state == axil_write_resp);
   assign araddr  = addr_q;
   assign arprot  = 3'b000;
   assign arvalid = (state == axil_read_addr);
   assign rready  = (state == axil_read_data);

   assign native.ready = ready_q;
   assign native.rdata = rdata_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= axil_idle;
         aw_pend_q <= 1'b0;
         w_pend_q  <= 1'b0;
         ready_q   <= 1'b0;
      end else begin
         ready_q <= 1'b0;
         case (state)
            axil_idle: begin
               if (native.valid && !ready_q) begin
                  if (|native.wstrb) begin
                     aw_pend_q <= 1'b1;
                     w_pend_q  <= 1'b1;
                     state     <= axil_write_addr_data;
                  end else begin
                     state <= axil_read_addr;
                  end
               end
            end
            axil_write_addr_data: begin
               if (awready) aw_pend_q <= 1'b0;
               if (wready) w_pend_q <= 1'b0;
               if (aw_done && w_done) begin
                  state <= axil_write_resp;
               end
            end
            axil_write_resp: begin
               if (bvalid) begin
                  ready_q <= 1'b1;
                  state   <= axil_idle;
               end
            end
            axil_read_addr: if (arready) state <= axil_read_data;
            axil_read_data: begin
               if (rvalid) begin
                  ready_q <= 1'b1;
                  state   <= axil_idle;
               end
            end
            default: state <= axil_idle;
         endcase
      end
   end

   // Request captured at accept so AXI fields stay put under back-pressure
   always_ff @(posedge clk) begin
      if (state == axil_idle && native.valid && !ready_q) begin
         addr_q  <= native.addr;
         wdata_q <= native.wdata;
         wstrb_q <= native.wstrb;
      end
      if (state == axil_read_data && rvalid) begin
         rdata_q <= rdata;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/bus_merge.sv ====
`default_nettype none

module bus_merge #(
   parameter int N_PORTS = 2
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      invalidate,
   mem_bus_if.slave  masters [N_PORTS],
   mem_bus_if.master slave,
   output logic      flush
);
   import ext_mem_pkg::*;

   localparam int SEL_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

   logic [N_PORTS-1:0] req_valid;
   native_req_t        reqs [N_PORTS];
   native_req_t        granted;
   logic [SEL_W-1:0]   pick;
   logic [SEL_W-1:0]   sel;

   logic [SEL_W-1:0] last_q;      // Last winner, also the held grant
   logic             locked_q;
   logic             pending_q;   // Invalidate waiting for an idle bus

   for (genvar i = 0; i < N_PORTS; i++) begin : g_port
      assign req_valid[i] = masters[i].valid;
      assign reqs[i]      = {masters[i].addr, masters[i].wdata, masters[i].wstrb};

      // Only the winner sees ready
      assign masters[i].ready = slave.ready && (sel == SEL_W'(i));
      assign masters[i].rdata = slave.rdata;
   end

   // First requester after the last winner
   always_comb begin
      int unsigned idx;
      logic        found;
      pick  = last_q;
      found = 1'b0;
      for (int k = 1; k <= N_PORTS; k++) begin
         idx = (int'(last_q) + k) % N_PORTS;
         if (!found && req_valid[idx]) begin
            pick  = SEL_W'(idx);
            found = 1'b1;
         end
      end
   end

   assign sel     = locked_q ? last_q : pick;
   assign granted = reqs[sel];

   assign slave.valid = req_valid[sel];
   assign slave.addr  = granted.addr;
   assign slave.wdata = granted.wdata;
   assign slave.wstrb = granted.wstrb;

   assign flush = pending_q && !(|req_valid);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         last_q    <= '0;
         locked_q  <= 1'b0;
         pending_q <= 1'b0;
      end else begin
         if (slave.valid) begin
            last_q <= sel;
         end
         locked_q <= slave.valid && !slave.ready;   // Hold grant until ready

         if (invalidate) begin
            pending_q <= 1'b1;
         end else if (flush) begin
            pending_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/ext_mem.sv ====
`default_nettype none

module ext_mem #(
   parameter int N_PORTS = 2,
   parameter int INDEX_W = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           invalidate,
   // Native ports, one per cache
   input  logic                           req_valid [N_PORTS],
   input  logic [ext_mem_pkg::ADDR_W-1:0] req_addr [N_PORTS],
   input  logic [ext_mem_pkg::DATA_W-1:0] req_wdata [N_PORTS],
   input  logic [ext_mem_pkg::STRB_W-1:0] req_wstrb [N_PORTS],
   output logic [ext_mem_pkg::DATA_W-1:0] resp_rdata [N_PORTS],
   output logic                           resp_ready [N_PORTS],
   // AXI4-Lite toward external memory
   output logic [ext_mem_pkg::ADDR_W-1:0] awaddr,
   output logic [2:0]                     awprot,
   output logic                           awvalid,
   input  logic                           awready,
   output logic [ext_mem_pkg::DATA_W-1:0] wdata,
   output logic [ext_mem_pkg::STRB_W-1:0] wstrb,
   output logic                           wvalid,
   input  logic                           wready,
   input  logic [1:0]                     bresp,
   input  logic                           bvalid,
   output logic                           bready,
   output logic [ext_mem_pkg::ADDR_W-1:0] araddr,
   output logic [2:0]                     arprot,
   output logic                           arvalid,
   input  logic                           arready,
   input  logic [ext_mem_pkg::DATA_W-1:0] rdata,
   input  logic [1:0]                     rresp,
   input  logic                           rvalid,
   output logic                           rready
);

   mem_bus_if front_if [N_PORTS] ();
   mem_bus_if back_if [N_PORTS] ();   // Cache back-ends into the merge
   mem_bus_if axil_if ();

   logic flush;

   for (genvar i = 0; i < N_PORTS; i++) begin : g_cache
      assign front_if[i].valid = req_valid[i];
      assign front_if[i].addr  = req_addr[i];
      assign front_if[i].wdata = req_wdata[i];
      assign front_if[i].wstrb = req_wstrb[i];
      assign resp_rdata[i]     = front_if[i].rdata;
      assign resp_ready[i]     = front_if[i].ready;

      l1_cache #(
         .INDEX_W (INDEX_W)
      ) cache_i (
         .clk   (clk),
         .rst   (rst),
         .flush (flush),
         .front (front_if[i]),
         .back  (back_if[i])
      );
   end

   bus_merge #(
      .N_PORTS (N_PORTS)
   ) merge_i (
      .clk        (clk),
      .rst        (rst),
      .invalidate (invalidate),
      .masters    (back_if),
      .slave      (axil_if),
      .flush      (flush)
   );

   axil_master axil_i (
      .clk     (clk),
      .rst     (rst),
      .native  (axil_if),
      .awaddr  (awaddr),
      .awprot  (awprot),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arprot  (arprot),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

endmodule

`default_nettype wire

// ==== rtl/ext_mem_pkg.sv ====
`default_nettype none

package ext_mem_pkg;

   // Bus widths, byte addressed with word-aligned 32-bit words
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Request fields as one word, used where several requests are muxed
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;   // Zero means read
   } native_req_t;

   typedef enum logic [1:0] {
      cache_idle,
      cache_lookup,
      cache_refill,
      cache_write_through
   } cache_state_e;

   typedef enum logic [2:0] {
      axil_idle,
      axil_write_addr_data,
      axil_write_resp,
      axil_read_addr,
      axil_read_data
   } axil_state_e;

endpackage

`default_nettype wire

// ==== rtl/l1_cache.sv ====
`default_nettype none

module l1_cache #(
   parameter int INDEX_W = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      flush,
   mem_bus_if.slave  front,
   mem_bus_if.master back
);
   import ext_mem_pkg::*;

   localparam int LINES = 1 << INDEX_W;
   localparam int TAG_W = ADDR_W - INDEX_W - 2;

   cache_state_e      state;
   logic [LINES-1:0]  line_valid;
   logic [TAG_W-1:0]  tag_mem [LINES];
   logic [DATA_W-1:0] data_mem [LINES];   // One word per line

   logic [INDEX_W-1:0] index;
   logic [TAG_W-1:0]   tag;
   logic               is_write;
   logic               hit;
   logic               fill;
   logic               store;

   logic [TAG_W-1:0]  tag_q;
   logic [DATA_W-1:0] data_q;
   logic              valid_q;
   logic              hit_q;
   logic              ready_q;
   logic [DATA_W-1:0] rdata_q;

   // Strobed bytes of new_w replace those of old_w
   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w,
      input logic [STRB_W-1:0] strb
   );
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Front request is held steady until ready, so it is used directly
   assign index    = front.addr[INDEX_W+1:2];
   assign tag      = front.addr[ADDR_W-1:INDEX_W+2];
   assign is_write = |front.wstrb;

   // A flush during lookup turns the access into a miss
   assign hit   = valid_q && !flush && (tag_q == tag);
   assign fill  = (state == cache_refill) && back.ready;
   assign store = (state == cache_write_through) && back.ready && hit_q;

   assign back.valid = (state == cache_refill) || (state == cache_write_through);
   assign back.addr  = {front.addr[ADDR_W-1:2], 2'b00};
   assign back.wdata = front.wdata;
   assign back.wstrb = (state == cache_write_through) ? front.wstrb : '0;

   assign front.ready = ready_q;
   assign front.rdata = rdata_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= cache_idle;
         line_valid <= '0;
         valid_q    <= 1'b0;
         hit_q      <= 1'b0;
         ready_q    <= 1'b0;
      end else begin
         ready_q <= 1'b0;   // Single-cycle pulse

         if (flush) begin
            line_valid <= '0;
         end else if (fill) begin
            line_valid[index] <= 1'b1;
         end

         case (state)
            cache_idle: begin
               // Ignore the request still held during our own ready
               if (front.valid && !ready_q) begin
                  valid_q <= line_valid[index] && !flush;
                  state   <= cache_lookup;
               end
            end
            cache_lookup: begin
               hit_q <= hit;
               if (is_write) begin
                  state <= cache_write_through;   // No allocate on a write miss
               end else if (hit) begin
                  ready_q <= 1'b1;
                  state   <= cache_idle;
               end else begin
                  state <= cache_refill;
               end
            end
            cache_refill, cache_write_through: begin
               if (back.ready) begin
                  ready_q <= 1'b1;
                  state   <= cache_idle;
               end
            end
            default: state <= cache_idle;
         endcase
      end
   end

   // Arrays and read paths
   always_ff @(posedge clk) begin
      if (state == cache_idle) begin
         tag_q  <= tag_mem[index];
         data_q <= data_mem[index];
      end
      if (state == cache_lookup) begin
         rdata_q <= data_q;   // Hit data
      end
      if (fill) begin
         tag_mem[index]  <= tag;
         data_mem[index] <= back.rdata;
         rdata_q         <= back.rdata;
      end
      if (store) begin
         data_mem[index] <= merge_bytes(data_q, front.wdata, front.wstrb);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mem_bus_if.sv ====
`default_nettype none

interface mem_bus_if;
   import ext_mem_pkg::*;

   logic              valid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;   // Nonzero for a write
   logic [DATA_W-1:0] rdata;
   logic              ready;   // One-cycle pulse ends the transfer

   // Requester side
   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   // Responder side
   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

`default_nettype wire

// ==== tests/ext_mem_checker.sv ====
`default_nettype none

module ext_mem_checker #(
   parameter int N_PORTS = 2
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req_valid [N_PORTS],
   input  logic                           resp_ready [N_PORTS],
   input  logic [ext_mem_pkg::DATA_W-1:0] resp_rdata [N_PORTS],
   input  logic                           exp_read [N_PORTS],
   input  logic [ext_mem_pkg::DATA_W-1:0] exp_rdata [N_PORTS],
   input  int                             exp_lat [N_PORTS],
   input  logic                           alt_check,
   input  logic                           awvalid,
   input  logic                           awready,
   input  logic [ext_mem_pkg::ADDR_W-1:0] awaddr,
   input  logic [2:0]                     awprot,
   input  logic                           wvalid,
   input  logic                           wready,
   input  logic [ext_mem_pkg::DATA_W-1:0] wdata,
   input  logic [ext_mem_pkg::STRB_W-1:0] wstrb,
   input  logic                           arvalid,
   input  logic                           arready,
   input  logic [ext_mem_pkg::ADDR_W-1:0] araddr,
   input  logic [2:0]                     arprot,
   output int                             errors,
   output int                             ar_count,
   output int                             aw_count
);
   timeunit 1ns;
   timeprecision 100ps;
   import ext_mem_pkg::*;

   int                lat [N_PORTS];
   logic              aw_held;
   logic              w_held;
   logic              ar_held;
   logic [ADDR_W-1:0] awaddr_q;
   logic [ADDR_W-1:0] araddr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] wstrb_q;
   logic              seen_ar;
   logic              last_region;

   // Sampled mid-cycle, where DUT outputs and driven inputs are settled
   always @(negedge clk) begin
      if (rst) begin
         errors   = 0;
         ar_count = 0;
         aw_count = 0;
         aw_held  = 1'b0;
         w_held   = 1'b0;
         ar_held  = 1'b0;
         seen_ar  = 1'b0;
         for (int p = 0; p < N_PORTS; p++) lat[p] = 0;
      end else begin
         for (int p = 0; p < N_PORTS; p++) begin
            if (resp_ready[p]) begin
               if (exp_read[p] && resp_rdata[p] !== exp_rdata[p]) begin
                  $display("mismatch resp_rdata[%0d] got %h exp %h", p, resp_rdata[p],
                           exp_rdata[p]);
                  errors++;
               end
               if (exp_lat[p] != 0 && lat[p] != exp_lat[p]) begin
                  $display("mismatch resp_ready[%0d] latency got %h exp %h", p, lat[p],
                           exp_lat[p]);
                  errors++;
               end
               lat[p] = 0;
            end else if (req_valid[p]) begin
               lat[p]++;
            end
         end

         // Protection fields are always zero
         if (awvalid && awprot !== 3'b000) begin
            $display("mismatch awprot got %h exp %h", awprot, 3'b000);
            errors++;
         end
         if (arvalid && arprot !== 3'b000) begin
            $display("mismatch arprot got %h exp %h", arprot, 3'b000);
            errors++;
         end

         // A held valid keeps its fields until its ready
         if (aw_held && (!awvalid || awaddr !== awaddr_q)) begin
            $display("awvalid dropped or awaddr changed before awready");
            errors++;
         end
         if (w_held && (!wvalid || wdata !== wdata_q || wstrb !== wstrb_q)) begin
            $display("wvalid dropped or write data changed before wready");
            errors++;
         end
         if (ar_held && (!arvalid || araddr !== araddr_q)) begin
            $display("arvalid dropped or araddr changed before arready");
            errors++;
         end
         aw_held  = awvalid && !awready;
         w_held   = wvalid && !wready;
         ar_held  = arvalid && !arready;
         awaddr_q = awaddr;
         araddr_q = araddr;
         wdata_q  = wdata;
         wstrb_q  = wstrb;

         if (awvalid && awready) aw_count++;
         if (!alt_check) seen_ar = 1'b0;
         if (arvalid && arready) begin
            ar_count++;
            // Port regions differ in address bit 13
            if (alt_check && seen_ar && araddr[13] == last_region) begin
               $display("arbitration did not alternate at read address %h", araddr);
               errors++;
            end
            last_region = araddr[13];
            seen_ar     = alt_check;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_ext_mem.sv ====
`default_nettype none

module tb_ext_mem;
   timeunit 1ns;
   timeprecision 100ps;
   import ext_mem_pkg::*;

   localparam int N_PORTS = 2;
   localparam int INDEX_W = 4;
   localparam int TIMEOUT = 300;   // Cycles per wait

   logic              clk = 1'b0;
   logic              rst;
   logic              invalidate;
   logic              req_valid [N_PORTS];
   logic [ADDR_W-1:0] req_addr [N_PORTS];
   logic [DATA_W-1:0] req_wdata [N_PORTS];
   logic [STRB_W-1:0] req_wstrb [N_PORTS];
   logic [DATA_W-1:0] resp_rdata [N_PORTS];
   logic              resp_ready [N_PORTS];
   logic [ADDR_W-1:0] awaddr;
   logic [ADDR_W-1:0] araddr;
   logic [2:0]        awprot;
   logic [2:0]        arprot;
   logic              awvalid;
   logic              awready;
   logic              wvalid;
   logic              wready;
   logic              bvalid;
   logic              bready;
   logic              arvalid;
   logic              arready;
   logic              rvalid;
   logic              rready;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;
   logic [STRB_W-1:0] wstrb;
   logic [1:0]        bresp = 2'b00;
   logic [1:0]        rresp = 2'b00;

   logic              exp_read [N_PORTS];
   logic [DATA_W-1:0] exp_rdata [N_PORTS];
   int                exp_lat [N_PORTS];
   logic              alt_check;
   int                errors;
   int                ar_count;
   int                aw_count;

   // Memory model state and the reference shadows
   logic [DATA_W-1:0] model_mem [logic [ADDR_W-1:0]];
   logic [DATA_W-1:0] shadow_mem [logic [ADDR_W-1:0]];
   logic              c_valid [N_PORTS][1 << INDEX_W];
   logic [ADDR_W-1:0] c_addr [N_PORTS][1 << INDEX_W];
   logic [DATA_W-1:0] c_data [N_PORTS][1 << INDEX_W];
   logic [ADDR_W-1:0] last_awaddr;
   logic [DATA_W-1:0] last_wdata;
   logic [STRB_W-1:0] last_wstrb;
   int                tb_errors;
   int                test_no;
   int                fails;

   always #20 clk = ~clk;

   ext_mem #(.N_PORTS(N_PORTS), .INDEX_W(INDEX_W)) dut_i (
      .clk(clk), .rst(rst), .invalidate(invalidate),
      .req_valid(req_valid), .req_addr(req_addr), .req_wdata(req_wdata),
      .req_wstrb(req_wstrb), .resp_rdata(resp_rdata), .resp_ready(resp_ready),
      .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   ext_mem_checker #(.N_PORTS(N_PORTS)) checker_i (
      .clk(clk), .rst(rst), .req_valid(req_valid), .resp_ready(resp_ready),
      .resp_rdata(resp_rdata), .exp_read(exp_read), .exp_rdata(exp_rdata),
      .exp_lat(exp_lat), .alt_check(alt_check),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awprot(awprot),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .arvalid(arvalid), .arready(arready), .araddr(araddr), .arprot(arprot),
      .errors(errors), .ar_count(ar_count), .aw_count(aw_count)
   );

   // Unwritten words of external memory
   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
      return {a, ~a} ^ 32'h1357_9bdf;
   endfunction

   function automatic logic [DATA_W-1:0] merge_strobed(input logic [DATA_W-1:0] old_w,
         input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] s);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) if (s[b]) res[8*b +: 8] = new_w[8*b +: 8];
      return res;
   endfunction

   function automatic logic [DATA_W-1:0] shadow_word(input logic [ADDR_W-1:0] a);
      return shadow_mem.exists(a) ? shadow_mem[a] : fill_word(a);
   endfunction

   // Reference: a cached line wins, otherwise memory as last written
   function automatic logic [DATA_W-1:0] expected_word(input int p,
         input logic [ADDR_W-1:0] a);
      int i;
      i = int'(a[INDEX_W+1:2]);
      if (c_valid[p][i] && c_addr[p][i] == a) return c_data[p][i];
      return shadow_word(a);
   endfunction

   task automatic note_access(input int p, input logic [ADDR_W-1:0] a,
         input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
      int i;
      i = int'(a[INDEX_W+1:2]);
      if (s == '0) begin
         c_data[p][i]  = expected_word(p, a);   // Miss fills the line
         c_valid[p][i] = 1'b1;
         c_addr[p][i]  = a;
      end else begin
         shadow_mem[a] = merge_strobed(shadow_word(a), d, s);
         if (c_valid[p][i] && c_addr[p][i] == a) begin
            c_data[p][i] = merge_strobed(c_data[p][i], d, s);   // Write hit only
         end
      end
   endtask

   task automatic access(input int p, input logic [ADDR_W-1:0] a,
         input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s, input int lat);
      int t;
      exp_read[p]  = (s == '0);
      exp_rdata[p] = expected_word(p, a);
      exp_lat[p]   = lat;
      note_access(p, a, d, s);
      @(posedge clk);
      #2;
      req_valid[p] = 1'b1;
      req_addr[p]  = a;
      req_wdata[p] = d;
      req_wstrb[p] = s;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!resp_ready[p] && t < TIMEOUT);
      if (!resp_ready[p]) begin
         $display("timeout: port %0d got no ready for address %h", p, a);
         $display("sim failed");
         $finish;
      end else begin
         @(posedge clk);
         #2;
         req_valid[p] = 1'b0;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
         input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s got %h exp %h", name, got, exp);
         tb_errors++;
      end
   endtask

   task automatic finish_test(input string name, input int err_base);
      int n;
      n = errors + tb_errors - err_base;
      test_no++;
      if (n != 0) fails++;
      $display("test %0d %s: %s (%0d errors)", test_no, name, (n == 0) ? "ok" : "FAILED", n);
   endtask

   // AXI4-Lite memory model with random ready and response delays
   initial begin
      logic              aw_hs;
      logic              w_hs;
      logic              ar_hs;
      logic              b_hs;
      logic              r_hs;
      logic              aw_got;
      logic              w_got;
      logic [ADDR_W-1:0] ar_addr_s;
      int                b_wait;
      int                r_wait;
      awready = 1'b0;
      wready  = 1'b0;
      arready = 1'b0;
      bvalid  = 1'b0;
      rvalid  = 1'b0;
      rdata   = '0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
      b_wait  = 0;
      r_wait  = 0;
      forever begin
         @(negedge clk);   // Handshakes as the next rising edge sees them
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         ar_hs = arvalid && arready;
         b_hs  = bvalid && bready;
         r_hs  = rvalid && rready;
         if (aw_hs) last_awaddr = awaddr;
         if (w_hs) begin
            last_wdata = wdata;
            last_wstrb = wstrb;
         end
         ar_addr_s = araddr;
         @(posedge clk);
         #2;
         if (b_hs) bvalid = 1'b0;
         if (r_hs) rvalid = 1'b0;
         aw_got = aw_got || aw_hs;
         w_got  = w_got || w_hs;
         if (aw_got && w_got) begin
            model_mem[last_awaddr] = merge_strobed(model_mem.exists(last_awaddr) ?
               model_mem[last_awaddr] : fill_word(last_awaddr), last_wdata, last_wstrb);
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_wait = 3 + int'($urandom % 4);
         end
         if (ar_hs) begin
            rdata  = model_mem.exists(ar_addr_s) ? model_mem[ar_addr_s] : fill_word(ar_addr_s);
            r_wait = 3 + int'($urandom % 4);
         end
         if (b_wait > 0) begin
            b_wait--;
            if (b_wait == 0) bvalid = 1'b1;
         end
         if (r_wait > 0) begin
            r_wait--;
            if (r_wait == 0) rvalid = 1'b1;
         end
         awready = 1'($urandom % 2);
         wready  = 1'($urandom % 2);
         arready = 1'($urandom % 2);
      end
   end

   initial begin
      int                base;
      int                ar0;
      int                aw0;
      void'($urandom(43));
      rst        = 1'b1;
      invalidate = 1'b0;
      alt_check  = 1'b0;
      tb_errors  = 0;
      test_no    = 0;
      fails      = 0;
      for (int p = 0; p < N_PORTS; p++) begin
         req_valid[p] = 1'b0;
         req_addr[p]  = '0;
         req_wdata[p] = '0;
         req_wstrb[p] = '0;
         exp_read[p]  = 1'b0;
         exp_rdata[p] = '0;
         exp_lat[p]   = 0;
         for (int i = 0; i < (1 << INDEX_W); i++) c_valid[p][i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      // Read miss, then a hit on the same word
      base = errors + tb_errors;
      ar0  = ar_count;
      access(0, 16'h0100, '0, '0, 0);
      check_value("ar_count", ar_count, ar0 + 1);
      access(0, 16'h0100, '0, '0, 2);
      check_value("ar_count", ar_count, ar0 + 1);
      finish_test("read miss then hit", base);

      // Strobed writes, to a cached and to an uncached word
      base = errors + tb_errors;
      aw0  = aw_count;
      access(0, 16'h0100, 32'haabb_ccdd, 4'b0101, 0);
      check_value("aw_count", aw_count, aw0 + 1);
      check_value("awaddr", last_awaddr, 16'h0100);
      check_value("wdata", last_wdata, 32'haabb_ccdd);
      check_value("wstrb", last_wstrb, 4'b0101);
      access(0, 16'h0100, '0, '0, 0);
      access(0, 16'h0200, 32'h1122_3344, 4'b1000, 0);
      access(0, 16'h0200, '0, '0, 0);
      finish_test("strobed write then read", base);

      // Stale line on the other port until an invalidate
      base = errors + tb_errors;
      access(1, 16'h0300, '0, '0, 0);
      access(0, 16'h0300, 32'h1234_5678, 4'hf, 0);
      access(1, 16'h0300, '0, '0, 0);
      @(posedge clk);
      #2;
      invalidate = 1'b1;
      @(posedge clk);
      #2;
      invalidate = 1'b0;
      repeat (3) @(posedge clk);
      for (int p = 0; p < N_PORTS; p++) begin
         for (int i = 0; i < (1 << INDEX_W); i++) c_valid[p][i] = 1'b0;
      end
      ar0 = ar_count;
      access(1, 16'h0300, '0, '0, 0);
      check_value("ar_count", ar_count, ar0 + 1);
      finish_test("invalidate clears stale line", base);

      // Concurrent misses, both ports
      base      = errors + tb_errors;
      ar0       = ar_count;
      alt_check = 1'b1;
      access(0, 16'h1010, '0, '0, 0);   // Port 0 last winner, so port 1 goes first
      fork
         for (int k = 0; k < 4; k++) access(0, 16'h1000 + 16'(4 * k), '0, '0, 0);
         for (int k = 0; k < 4; k++) access(1, 16'h2000 + 16'(4 * k), '0, '0, 0);
      join
      alt_check = 1'b0;
      check_value("ar_count", ar_count, ar0 + 9);
      finish_test("concurrent misses alternate", base);

      // Random mixed traffic, each port in its own region
      base = errors + tb_errors;
      for (int p = 0; p < N_PORTS; p++) begin
         fork
            automatic int q = p;
            for (int k = 0; k < 40; k++) begin
               if ($urandom % 3 == 0) begin
                  access(q, 16'h4000 + 16'(q * 16'h1000) + 16'(4 * ($urandom % 32)),
                         $urandom, 4'(1 + $urandom % 15), 0);
               end else begin
                  access(q, 16'h4000 + 16'(q * 16'h1000) + 16'(4 * ($urandom % 32)),
                         '0, '0, 0);
               end
            end
         join_none
      end
      wait fork;
      finish_test("random traffic", base);

      $display("tests %0d, failed %0d, errors %0d, ar %0d, aw %0d", test_no, fails,
               errors + tb_errors, ar_count, aw_count);
      if (fails == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
